/* hdl/cnn_pkg.sv */
package cnn_pkg;

	localparam int DATA_W = 16;
	localparam int IN_CH  = 3;
	localparam int KERNEL = 3;
	localparam int TAPS   = KERNEL * KERNEL;

	// 27 products of 32 bits plus a bias.
	localparam int ACC_W  = 38;

	// Channel 0 in the low bits.
	typedef logic [IN_CH-1:0][DATA_W-1:0] pixel_t;

	typedef struct packed {
		logic [IN_CH*DATA_W-DATA_W-1:0] pad;
		logic [DATA_W-1:0]              value;
	} bias_view_t;

	// One load word, read as three weights or as one bias.
	typedef union packed {
		pixel_t     weight;
		bias_view_t bias;
	} coef_word_u;

	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* hdl/conv_ctrl_if.sv */
`timescale 1ns/1ps

interface conv_ctrl_if;

	logic pix_shift;  // Pixel accepted this cycle.
	logic wt_shift;
	logic bias_shift;
	logic win_valid;  // Accepted pixel completes an inner window.

	modport ctrl (
		output pix_shift,
		output wt_shift,
		output bias_shift,
		output win_valid
	);

	modport dp (
		input pix_shift,
		input wt_shift,
		input bias_shift,
		input win_valid
	);

endinterface

/* hdl/line_delay.sv */
`timescale 1ns/1ps

module line_delay #(
	parameter int DEPTH = 5
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            shift_en,
	input  cnn_pkg::pixel_t din,
	output cnn_pkg::pixel_t dout
);

	cnn_pkg::pixel_t sr [DEPTH];

	assign dout = sr[DEPTH-1];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				sr[i] <= '0;
			end
		end
		else if (shift_en)
		begin
			sr[0] <= din;
			for (int i = 1; i < DEPTH; i++)
			begin
				sr[i] <= sr[i-1];
			end
		end
	end

endmodule

/* hdl/conv_ctrl.sv */
`timescale 1ns/1ps

module conv_ctrl #(
	parameter int IMG_W = 8
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        pix_valid,
	input  logic        coef_valid,
	input  logic        coef_is_bias,
	conv_ctrl_if.ctrl   ctrl
);

	localparam int COL_W = $clog2(IMG_W);

	logic [COL_W-1:0] col;  // Column of the next pixel.
	logic [1:0]       row;  // Saturates at 2.
	logic             col_last;

	assign col_last = (col == COL_W'(IMG_W - 1));

	assign ctrl.pix_shift  = pix_valid;
	assign ctrl.wt_shift   = coef_valid & ~coef_is_bias;
	assign ctrl.bias_shift = coef_valid & coef_is_bias;

	// Window needs two rows and two columns before this pixel.
	assign ctrl.win_valid  = pix_valid && (col >= COL_W'(2)) && (row == 2'd2);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col <= '0;
			row <= '0;
		end
		else if (pix_valid)
		begin
			if (col_last)
			begin
				col <= '0;
				if (row != 2'd2)
				begin
					row <= row + 2'd1;
				end
			end
			else
			begin
				col <= col + COL_W'(1);
			end
		end
	end

endmodule

/* hdl/window_gen.sv */
`timescale 1ns/1ps

module window_gen #(
	parameter int IMG_W = 8
) (
	input  logic            clk,
	input  logic            rst,
	conv_ctrl_if.dp         ctrl,
	input  cnn_pkg::pixel_t pix_data,
	output cnn_pkg::pixel_t taps [cnn_pkg::TAPS]
);

	localparam int K = cnn_pkg::KERNEL;

	// Row 0 is the oldest row, column 0 the leftmost pixel.
	cnn_pkg::pixel_t win    [K][K];
	cnn_pkg::pixel_t row_in [K];
	cnn_pkg::pixel_t ld_out [K-1];

	for (genvar r = 0; r < K - 1; r++)
	begin : g_line
		line_delay #(
			.DEPTH (IMG_W - K)
		) u_line_delay (
			.clk      (clk),
			.rst      (rst),
			.shift_en (ctrl.pix_shift),
			.din      (win[r+1][0]),
			.dout     (ld_out[r])
		);
	end

	always_comb
	begin
		row_in[K-1] = pix_data;
		for (int r = 0; r < K - 1; r++)
		begin
			row_in[r] = ld_out[r];
		end
		for (int t = 0; t < cnn_pkg::TAPS; t++)
		begin
			taps[t] = win[t / K][t % K];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < K; r++)
			begin
				for (int c = 0; c < K; c++)
				begin
					win[r][c] <= '0;
				end
			end
		end
		else if (ctrl.pix_shift)
		begin
			for (int r = 0; r < K; r++)
			begin
				win[r][K-1] <= row_in[r];  // Enters on the right.
				for (int c = 0; c < K - 1; c++)
				begin
					win[r][c] <= win[r][c+1];
				end
			end
		end
	end

endmodule

/* hdl/coef_store.sv */
`timescale 1ns/1ps

module coef_store #(
	parameter int OUT_CH = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	conv_ctrl_if.dp                     ctrl,
	input  cnn_pkg::coef_word_u         coef_word,
	output cnn_pkg::pixel_t             weights [OUT_CH][cnn_pkg::TAPS],
	output logic [cnn_pkg::DATA_W-1:0]  biases  [OUT_CH]
);

	localparam int N_WT = OUT_CH * cnn_pkg::TAPS;

	// Oldest of the last N_WT words ends up at position 0.
	cnn_pkg::pixel_t wt_chain [N_WT];

	always_comb
	begin
		for (int ch = 0; ch < OUT_CH; ch++)
		begin
			for (int t = 0; t < cnn_pkg::TAPS; t++)
			begin
				weights[ch][t] = wt_chain[ch * cnn_pkg::TAPS + t];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < N_WT; i++)
			begin
				wt_chain[i] <= '0;
			end
		end
		else if (ctrl.wt_shift)
		begin
			wt_chain[N_WT-1] <= coef_word.weight;
			for (int i = 0; i < N_WT - 1; i++)
			begin
				wt_chain[i] <= wt_chain[i+1];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < OUT_CH; i++)
			begin
				biases[i] <= '0;
			end
		end
		else if (ctrl.bias_shift)
		begin
			biases[OUT_CH-1] <= coef_word.bias.value;  // Low 16 bits only.
			for (int i = 0; i < OUT_CH - 1; i++)
			begin
				biases[i] <= biases[i+1];
			end
		end
	end

endmodule

/* hdl/conv_mac.sv */
`timescale 1ns/1ps

module conv_mac #(
	parameter int OUT_CH = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	conv_ctrl_if.dp                            ctrl,
	input  cnn_pkg::pixel_t                    taps    [cnn_pkg::TAPS],
	input  cnn_pkg::pixel_t                    weights [OUT_CH][cnn_pkg::TAPS],
	input  logic [cnn_pkg::DATA_W-1:0]         biases  [OUT_CH],
	output logic                               out_valid,
	output logic [OUT_CH*cnn_pkg::DATA_W-1:0]  out_data
);

	localparam int PROD_N = cnn_pkg::TAPS * cnn_pkg::IN_CH;
	localparam int LEAVES = 2 ** $clog2(PROD_N);

	cnn_pkg::acc_t sum [OUT_CH];
	logic          win_q;  // Window formed at the last edge.

	for (genvar ch = 0; ch < OUT_CH; ch++)
	begin : g_ch
		// Heap-ordered tree with node 1 at the root.
		cnn_pkg::acc_t node [1:2*LEAVES-1];

		always_comb
		begin
			for (int i = 0; i < LEAVES; i++)
			begin
				node[LEAVES+i] = '0;
			end
			for (int t = 0; t < cnn_pkg::TAPS; t++)
			begin
				for (int c = 0; c < cnn_pkg::IN_CH; c++)
				begin
					node[LEAVES + t*cnn_pkg::IN_CH + c] =
						$signed(taps[t][c]) * $signed(weights[ch][t][c]);
				end
			end
			for (int i = LEAVES - 1; i > 0; i--)
			begin
				node[i] = node[2*i] + node[2*i+1];
			end
			sum[ch] = node[1] + $signed(biases[ch]);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_q     <= 1'b0;
			out_valid <= 1'b0;
			out_data  <= '0;
		end
		else
		begin
			win_q     <= ctrl.win_valid;
			out_valid <= win_q;
			if (win_q)
			begin
				for (int ch = 0; ch < OUT_CH; ch++)
				begin
					out_data[ch*cnn_pkg::DATA_W +: cnn_pkg::DATA_W] <=
						sum[ch][cnn_pkg::DATA_W-1:0];  // Wraps.
				end
			end
		end
	end

endmodule

/* hdl/cnn_conv_top.sv */
`timescale 1ns/1ps

module cnn_conv_top #(
	parameter int IMG_W  = 8,
	parameter int OUT_CH = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               pix_valid,
	input  cnn_pkg::pixel_t                    pix_data,
	input  logic                               coef_valid,
	input  logic                               coef_is_bias,
	input  cnn_pkg::coef_word_u                coef_word,
	output logic                               out_valid,
	output logic [OUT_CH*cnn_pkg::DATA_W-1:0]  out_data
);

	cnn_pkg::pixel_t             taps    [cnn_pkg::TAPS];
	cnn_pkg::pixel_t             weights [OUT_CH][cnn_pkg::TAPS];
	logic [cnn_pkg::DATA_W-1:0]  biases  [OUT_CH];

	conv_ctrl_if u_ctrl_if ();

	conv_ctrl #(
		.IMG_W (IMG_W)
	) u_conv_ctrl (
		.clk          (clk),
		.rst          (rst),
		.pix_valid    (pix_valid),
		.coef_valid   (coef_valid),
		.coef_is_bias (coef_is_bias),
		.ctrl         (u_ctrl_if.ctrl)
	);

	window_gen #(
		.IMG_W (IMG_W)
	) u_window_gen (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (u_ctrl_if.dp),
		.pix_data (pix_data),
		.taps     (taps)
	);

	coef_store #(
		.OUT_CH (OUT_CH)
	) u_coef_store (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (u_ctrl_if.dp),
		.coef_word (coef_word),
		.weights   (weights),
		.biases    (biases)
	);

	conv_mac #(
		.OUT_CH (OUT_CH)
	) u_conv_mac (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (u_ctrl_if.dp),
		.taps      (taps),
		.weights   (weights),
		.biases    (biases),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

/* dv/cnn_conv_tb.sv */
`timescale 1ns/1ps

module cnn_conv_tb;

	localparam int IMG_W   = 8;
	localparam int OUT_CH  = 4;
	localparam int DW      = cnn_pkg::DATA_W;
	localparam int OUT_W   = OUT_CH * DW;
	localparam int N_WT    = OUT_CH * cnn_pkg::TAPS;
	localparam int MAX_PIX = 8 * IMG_W;
	localparam int N_CASE  = 6;

	typedef enum logic [1:0] {WT_ONES, WT_RAND, WT_NEG, WT_KEEP} wt_mode_e;
	typedef enum logic [1:0] {PIX_CONST, PIX_RAMP, PIX_RAND} pix_mode_e;

	typedef struct packed {
		wt_mode_e                wt_mode;
		pix_mode_e               pix_mode;
		int                      rows;
		logic                    gaps;
		int                      extra;      // Words pushed out later.
		logic [DW-1:0]           pix_const;
		logic [OUT_CH-1:0][DW-1:0] bias;
		logic [OUT_CH-1:0][DW-1:0] exp_const;  // Channel 3 first.
	} case_t;

	// Case 3 repeats case 2 with gaps in pix_valid.
	case_t cases [N_CASE] = '{
		'{WT_ONES, PIX_CONST, 5, 1'b0, 0, 16'd100, {4{16'd5}}, {4{16'h0A91}}},
		'{WT_ONES, PIX_CONST, 4, 1'b0, 0, 16'h1000,
			{16'h5000, 16'hFFFF, 16'h0020, 16'h0010},
			{16'h0000, 16'hAFFF, 16'hB020, 16'hB010}},
		'{WT_RAND, PIX_RAMP,  6, 1'b0, 0,  16'd0, {16'd4, 16'd3, 16'd2, 16'd1}, '0},
		'{WT_KEEP, PIX_RAMP,  6, 1'b1, 0,  16'd0, {16'd4, 16'd3, 16'd2, 16'd1}, '0},
		'{WT_NEG,  PIX_RAND,  4, 1'b0, 7,  16'd0, {16'h8000, 16'h7FFF, 16'd9, 16'hFFF0}, '0},
		'{WT_RAND, PIX_RAND,  5, 1'b1, 40, 16'd0, {16'h1234, 16'd0, 16'hABCD, 16'd77}, '0}
	};

	logic                 clk;
	logic                 rst;
	logic                 pix_valid;
	cnn_pkg::pixel_t      pix_data;
	logic                 coef_valid;
	logic                 coef_is_bias;
	cnn_pkg::coef_word_u  coef_word;
	logic                 out_valid;
	logic [OUT_W-1:0]     out_data;

	cnn_pkg::pixel_t  frame  [MAX_PIX];
	cnn_pkg::pixel_t  wt     [OUT_CH][cnn_pkg::TAPS];
	logic [DW-1:0]    bias_v [OUT_CH];
	logic [OUT_W-1:0] exp_q  [$];
	int               res_count;

	cnn_conv_top #(
		.IMG_W  (IMG_W),
		.OUT_CH (OUT_CH)
	) u_cnn_conv_top (
		.clk          (clk),
		.rst          (rst),
		.pix_valid    (pix_valid),
		.pix_data     (pix_data),
		.coef_valid   (coef_valid),
		.coef_is_bias (coef_is_bias),
		.coef_word    (coef_word),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "%s", what);
	endtask

	task automatic check_out(input logic [OUT_W-1:0] got, input logic [OUT_W-1:0] exp);
		if (got !== exp)
		begin
			fail_run($sformatf("MISMATCH time=%0t signal=out_data got=%h exp=%h",
				$time, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp)
		begin
			fail_run($sformatf("MISMATCH time=%0t signal=out_valid_count got=%0d exp=%0d",
				$time, got, exp));
		end
	endtask

	// Advance one cycle and check any result.
	task automatic step_cycle();
		logic [OUT_W-1:0] exp;
		@(negedge clk);
		if (out_valid)
		begin
			res_count++;
			if (exp_q.size() > 0)
			begin
				exp = exp_q.pop_front();
				check_out(out_data, exp);
			end
		end
	endtask

	function automatic cnn_pkg::pixel_t rand_pixel();
		cnn_pkg::pixel_t p;
		for (int k = 0; k < cnn_pkg::IN_CH; k++)
		begin
			p[k] = DW'($urandom);
		end
		return p;
	endfunction

	task automatic send_coef(input logic is_bias, input cnn_pkg::coef_word_u word);
		step_cycle();
		coef_valid   = 1'b1;
		coef_is_bias = is_bias;
		coef_word    = word;
	endtask

	task automatic load_coefs(input case_t tc);
		cnn_pkg::coef_word_u w;
		for (int n = 0; n < tc.extra; n++)
		begin
			w.weight = rand_pixel();
			send_coef(1'b0, w);
			send_coef(1'b1, w);
		end
		if (tc.wt_mode != WT_KEEP)
		begin
			for (int ch = 0; ch < OUT_CH; ch++)
			begin
				for (int t = 0; t < cnn_pkg::TAPS; t++)
				begin
					wt[ch][t] = rand_pixel();
					for (int k = 0; k < cnn_pkg::IN_CH; k++)
					begin
						if (tc.wt_mode == WT_ONES)
						begin
							wt[ch][t][k] = DW'(1);
						end
						else if (tc.wt_mode == WT_NEG)
						begin
							wt[ch][t][k][DW-1] = 1'b1;
						end
					end
				end
			end
		end
		for (int n = 0; n < N_WT; n++)
		begin
			w.weight = wt[n / cnn_pkg::TAPS][n % cnn_pkg::TAPS];
			send_coef(1'b0, w);
		end
		for (int ch = 0; ch < OUT_CH; ch++)
		begin
			w.weight     = rand_pixel();  // Upper bits stay as junk.
			w.bias.value = tc.bias[ch];
			bias_v[ch]   = tc.bias[ch];
			send_coef(1'b1, w);
		end
		step_cycle();
		coef_valid = 1'b0;
	endtask

	function automatic logic [OUT_W-1:0] model_window(input int r, input int c);
		logic [OUT_W-1:0] word;
		longint           acc;
		cnn_pkg::pixel_t  p;
		for (int ch = 0; ch < OUT_CH; ch++)
		begin
			acc = longint'($signed(bias_v[ch]));
			for (int t = 0; t < cnn_pkg::TAPS; t++)
			begin
				p = frame[(r - 2 + t / 3) * IMG_W + c - 2 + t % 3];
				for (int k = 0; k < cnn_pkg::IN_CH; k++)
				begin
					acc += longint'($signed(p[k])) * longint'($signed(wt[ch][t][k]));
				end
			end
			word[ch*DW +: DW] = acc[DW-1:0];
		end
		return word;
	endfunction

	task automatic run_case(input case_t tc);
		int gap;
		exp_q.delete();
		res_count = 0;
		rst       = 1'b1;
		pix_valid = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			step_cycle();
		end
		rst = 1'b0;
		load_coefs(tc);
		for (int i = 0; i < tc.rows * IMG_W; i++)
		begin
			for (int k = 0; k < cnn_pkg::IN_CH; k++)
			begin
				frame[i][k] = (tc.pix_mode == PIX_CONST) ? tc.pix_const : DW'(i * 3 + k);
			end
			if (tc.pix_mode == PIX_RAND)
			begin
				frame[i] = rand_pixel();
			end
		end
		for (int r = 2; r < tc.rows; r++)
		begin
			for (int c = 2; c < IMG_W; c++)
			begin
				exp_q.push_back((tc.pix_mode == PIX_CONST) ? tc.exp_const : model_window(r, c));
			end
		end
		for (int i = 0; i < tc.rows * IMG_W; i++)
		begin
			gap = tc.gaps ? $urandom_range(0, 2) : 0;
			for (int g = 0; g < gap; g++)
			begin
				step_cycle();
				pix_valid = 1'b0;
				pix_data  = rand_pixel();
			end
			step_cycle();
			pix_valid = 1'b1;
			pix_data  = frame[i];
		end
		step_cycle();
		pix_valid = 1'b0;
		for (int i = 0; i < 20 && exp_q.size() > 0; i++)
		begin
			step_cycle();
		end
		if (exp_q.size() > 0)
		begin
			fail_run("timed out waiting for out_valid");
		end
		for (int i = 0; i < 4; i++)
		begin
			step_cycle();  // Late extra pulses.
		end
		check_count(res_count, (IMG_W - 2) * (tc.rows - 2));
	endtask

	initial
	begin
		void'($urandom(32'h9176));
		rst          = 1'b1;
		pix_valid    = 1'b0;
		pix_data     = '0;
		coef_valid   = 1'b0;
		coef_is_bias = 1'b0;
		coef_word    = '0;
		res_count    = 0;
		for (int n = 0; n < N_CASE; n++)
		begin
			run_case(cases[n]);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* compile.f */
hdl/cnn_pkg.sv
hdl/conv_ctrl_if.sv
hdl/line_delay.sv
hdl/conv_ctrl.sv
hdl/window_gen.sv
hdl/coef_store.sv
hdl/conv_mac.sv
hdl/cnn_conv_top.sv
dv/cnn_conv_tb.sv

/* Bender.yml */
package:
  name: cnn_conv

sources:
  - files:
      - hdl/cnn_pkg.sv
      - hdl/conv_ctrl_if.sv
      - hdl/line_delay.sv
      - hdl/conv_ctrl.sv
      - hdl/window_gen.sv
      - hdl/coef_store.sv
      - hdl/conv_mac.sv
      - hdl/cnn_conv_top.sv
  - target: test
    files:
      - dv/cnn_conv_tb.sv
